// File: hw/stk_pkg.sv
// stack core package: widths, stack depth, opcode, error and controller state encodings
`default_nettype none

package stk_pkg;

	localparam int DATA_W      = 56;	// one stack item
	localparam int STACK_DEPTH = 8;
	localparam int DEPTH_W     = 4;	// holds 0..STACK_DEPTH
	localparam int OPC_W       = 7;
	localparam int INSTR_W     = 14;	// two opcodes, low one runs first

	// opcode values are contiguous, anything above OP_MUL is invalid
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 7'd0,
		OP_DEPTH = 7'd1,
		OP_DUP   = 7'd2,
		OP_DROP  = 7'd3,
		OP_INC   = 7'd4,	// one-operand words
		OP_DEC   = 7'd5,
		OP_NOT   = 7'd6,
		OP_COM   = 7'd7,
		OP_ADD   = 7'd8,	// two-operand words
		OP_SUB   = 7'd9,
		OP_AND   = 7'd10,
		OP_OR    = 7'd11,
		OP_XOR   = 7'd12,
		OP_SHL   = 7'd13,
		OP_SHR   = 7'd14,
		OP_GT    = 7'd15,
		OP_GTEQ  = 7'd16,
		OP_SM    = 7'd17,
		OP_SMEQ  = 7'd18,
		OP_EQ    = 7'd19,
		OP_NEQ   = 7'd20,
		OP_MUL   = 7'd21	// serial multiplier
	} opcode_e;

	typedef enum logic [3:0] {
		ERR_NONE    = 4'd0,
		ERR_DSFULL  = 4'd1,
		ERR_DSEMPTY = 4'd2,
		ERR_INVALID = 4'd3
	} err_e;

	// controller FSM
	typedef enum logic [2:0] {
		S_IDLE,
		S_PUSH,		// external constant push
		S_EXEC,		// decode current opcode
		S_SECOND,	// capture second operand
		S_RESULT,	// push alu result
		S_MUL_WAIT,
		S_SETTLE,	// stack command in flight
		S_NEXT		// advance to high opcode or finish
	} state_e;

endpackage

`default_nettype wire

// File: hw/stack_if.sv
// data stack port bundle between the controller and the stack storage
`default_nettype none

interface stack_if;

	// commands, one cycle pulses from the controller
	logic                        push;
	logic                        pop;
	logic [stk_pkg::DATA_W-1:0]  wdata;

	// status from the stack
	logic [stk_pkg::DATA_W-1:0]  rdata;	// current top of stack
	logic                        full;
	logic                        empty;
	logic [stk_pkg::DEPTH_W-1:0] depth;

	modport ctrl (
		output push, pop, wdata,
		input  rdata, full, empty, depth
	);

	modport mem (
		input  push, pop, wdata,
		output rdata, full, empty, depth
	);

endinterface

`default_nettype wire

// File: hw/data_stack.sv
// data stack: register array LIFO with depth count and top of stack read
`default_nettype none

module data_stack (
	input wire logic clk,
	input wire logic rst_n,
	stack_if.mem     stk
);

	logic [stk_pkg::DATA_W-1:0]  mem [stk_pkg::STACK_DEPTH];
	logic [stk_pkg::DEPTH_W-1:0] cnt;	// item count
	logic [stk_pkg::DEPTH_W-1:0] top_idx;

	assign top_idx = cnt - 1'b1;

	// depth counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (stk.push) begin
			cnt <= cnt + 1'b1;
		end else if (stk.pop) begin
			cnt <= cnt - 1'b1;
		end
	end

	// storage, next free slot is at cnt
	always_ff @(posedge clk) begin
		if (stk.push) begin
			mem[cnt[stk_pkg::DEPTH_W-2:0]] <= stk.wdata;
		end
	end

	assign stk.depth = cnt;
	assign stk.empty = (cnt == '0);
	assign stk.full  = (int'(cnt) == stk_pkg::STACK_DEPTH);
	assign stk.rdata = stk.empty ? '0 : mem[top_idx[stk_pkg::DEPTH_W-2:0]];

	// controller must check full and empty before issuing a command
	a_no_push_full: assert property (
		@(posedge clk) disable iff (!rst_n) stk.push |-> !stk.full
	) else $error("data stack push while full");

	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n) stk.pop |-> !stk.empty
	) else $error("data stack pop while empty");

endmodule

`default_nettype wire

// File: hw/stack_alu.sv
// stack alu: combinational result of the one- and two-operand words
`default_nettype none

module stack_alu (
	input  wire stk_pkg::opcode_e            i_op,
	input  wire logic [stk_pkg::DATA_W-1:0]  i_a,	// second item
	input  wire logic [stk_pkg::DATA_W-1:0]  i_b,	// top item
	output logic      [stk_pkg::DATA_W-1:0]  o_result
);

	always_comb begin
		o_result = '0;
		case (i_op)
			// unary words work on the top item
			stk_pkg::OP_INC:  o_result = i_b + 1'b1;
			stk_pkg::OP_DEC:  o_result = i_b - 1'b1;
			stk_pkg::OP_NOT:  o_result = ~i_b;
			stk_pkg::OP_COM:  o_result = ~i_b + 1'b1;	// two's complement

			// binary words, second op top
			stk_pkg::OP_ADD:  o_result = i_a + i_b;
			stk_pkg::OP_SUB:  o_result = i_a - i_b;
			stk_pkg::OP_AND:  o_result = i_a & i_b;
			stk_pkg::OP_OR:   o_result = i_a | i_b;
			stk_pkg::OP_XOR:  o_result = i_a ^ i_b;
			stk_pkg::OP_SHL:  o_result = i_a << i_b;
			stk_pkg::OP_SHR:  o_result = i_a >> i_b;

			// unsigned compares give 1 or 0
			stk_pkg::OP_GT:   o_result[0] = (i_a > i_b);
			stk_pkg::OP_GTEQ: o_result[0] = (i_a >= i_b);
			stk_pkg::OP_SM:   o_result[0] = (i_a < i_b);
			stk_pkg::OP_SMEQ: o_result[0] = (i_a <= i_b);
			stk_pkg::OP_EQ:   o_result[0] = (i_a == i_b);
			stk_pkg::OP_NEQ:  o_result[0] = (i_a != i_b);

			default:          o_result = '0;	// stack words and MUL
		endcase
	end

endmodule

`default_nettype wire

// File: hw/serial_mul.sv
// serial multiplier: unsigned shift-add, one multiplier bit per cycle
`default_nettype none

module serial_mul (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic                        i_start,
	input  wire logic [stk_pkg::DATA_W-1:0]  i_a,
	input  wire logic [stk_pkg::DATA_W-1:0]  i_b,
	output logic                             o_busy,
	output logic                             o_done,
	output logic      [stk_pkg::DATA_W-1:0]  o_product
);

	logic [stk_pkg::DATA_W-1:0]         acc;
	logic [stk_pkg::DATA_W-1:0]         mcand;	// shifts left
	logic [stk_pkg::DATA_W-1:0]         mplier;	// shifts right, lsb selects add
	logic [$clog2(stk_pkg::DATA_W)-1:0] bit_cnt;

	// control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_busy  <= 1'b0;
			o_done  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				o_busy  <= 1'b1;
				bit_cnt <= '0;
			end else if (o_busy) begin
				if (int'(bit_cnt) == stk_pkg::DATA_W - 1) begin
					o_busy <= 1'b0;	// last bit this cycle
					o_done <= 1'b1;
				end
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// datapath, bits above DATA_W are dropped
	always_ff @(posedge clk) begin
		if (i_start) begin
			acc    <= '0;
			mcand  <= i_a;
			mplier <= i_b;
		end else if (o_busy) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign o_product = acc;

endmodule

`default_nettype wire

// File: hw/core_ctrl.sv
// core controller: FSM sequencing pushes, pops, operand capture and both opcodes of a word
`default_nettype none

module core_ctrl (
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire logic [stk_pkg::DATA_W-1:0]   i_push_value,
	input  wire logic                         i_push_en,
	input  wire logic [stk_pkg::INSTR_W-1:0]  i_instr,
	input  wire logic                         i_instr_en,
	input  wire logic [stk_pkg::DATA_W-1:0]   i_alu_result,
	input  wire logic                         i_mul_busy,
	input  wire logic                         i_mul_done,
	input  wire logic [stk_pkg::DATA_W-1:0]   i_mul_product,
	stack_if.ctrl                             stk,
	output stk_pkg::opcode_e                  o_alu_op,
	output logic      [stk_pkg::DATA_W-1:0]   o_alu_a,
	output logic      [stk_pkg::DATA_W-1:0]   o_alu_b,
	output logic                              o_mul_start,
	output logic      [stk_pkg::DATA_W-1:0]   o_mul_a,
	output logic      [stk_pkg::DATA_W-1:0]   o_mul_b,
	output logic                              o_idle,
	output stk_pkg::err_e                     o_errcode
);

	stk_pkg::state_e            state;
	stk_pkg::state_e            ret_state;	// where S_SETTLE goes next
	logic [stk_pkg::OPC_W-1:0]  cur_op;
	logic [stk_pkg::OPC_W-1:0]  instr_hi;	// second opcode of the word
	logic                       second;	// running the high opcode
	logic [stk_pkg::DATA_W-1:0] opnd_a;	// second item
	logic [stk_pkg::DATA_W-1:0] opnd_b;	// top item

	// latch error and abort the rest of the word
	task automatic fail(input stk_pkg::err_e code);
		o_errcode <= code;
		state     <= stk_pkg::S_IDLE;
	endtask

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= stk_pkg::S_IDLE;
			stk.push    <= 1'b0;
			stk.pop     <= 1'b0;
			o_mul_start <= 1'b0;
			o_errcode   <= stk_pkg::ERR_NONE;
		end else begin
			stk.push    <= 1'b0;
			stk.pop     <= 1'b0;
			o_mul_start <= 1'b0;

			case (state)
				stk_pkg::S_IDLE: begin
					if (i_push_en) begin	// push wins over instruction
						stk.wdata <= i_push_value;
						state     <= stk_pkg::S_PUSH;
					end else if (i_instr_en) begin
						cur_op   <= i_instr[stk_pkg::OPC_W-1:0];
						instr_hi <= i_instr[stk_pkg::INSTR_W-1:stk_pkg::OPC_W];
						second   <= 1'b0;
						state    <= stk_pkg::S_EXEC;
					end
				end

				stk_pkg::S_PUSH: begin
					if (stk.full) begin
						fail(stk_pkg::ERR_DSFULL);
					end else begin
						stk.push  <= 1'b1;
						ret_state <= stk_pkg::S_IDLE;
						state     <= stk_pkg::S_SETTLE;
					end
				end

				stk_pkg::S_EXEC: begin
					ret_state <= stk_pkg::S_NEXT;
					state     <= stk_pkg::S_SETTLE;
					case (stk_pkg::opcode_e'(cur_op))
						stk_pkg::OP_NOP: state <= stk_pkg::S_NEXT;

						stk_pkg::OP_DEPTH: begin	// count before the push
							if (stk.full) begin
								fail(stk_pkg::ERR_DSFULL);
							end else begin
								stk.wdata <= {{(stk_pkg::DATA_W - stk_pkg::DEPTH_W){1'b0}},
								              stk.depth};
								stk.push  <= 1'b1;
							end
						end

						stk_pkg::OP_DUP: begin
							if (stk.empty) begin
								fail(stk_pkg::ERR_DSEMPTY);
							end else if (stk.full) begin
								fail(stk_pkg::ERR_DSFULL);
							end else begin
								stk.wdata <= stk.rdata;
								stk.push  <= 1'b1;
							end
						end

						stk_pkg::OP_DROP: begin
							if (stk.empty) begin
								fail(stk_pkg::ERR_DSEMPTY);
							end else begin
								stk.pop <= 1'b1;
							end
						end

						stk_pkg::OP_INC, stk_pkg::OP_DEC,
						stk_pkg::OP_NOT, stk_pkg::OP_COM: begin
							if (stk.empty) begin
								fail(stk_pkg::ERR_DSEMPTY);
							end else begin
								opnd_b    <= stk.rdata;
								stk.pop   <= 1'b1;
								ret_state <= stk_pkg::S_RESULT;
							end
						end

						stk_pkg::OP_ADD, stk_pkg::OP_SUB, stk_pkg::OP_AND,
						stk_pkg::OP_OR, stk_pkg::OP_XOR, stk_pkg::OP_SHL,
						stk_pkg::OP_SHR, stk_pkg::OP_GT, stk_pkg::OP_GTEQ,
						stk_pkg::OP_SM, stk_pkg::OP_SMEQ, stk_pkg::OP_EQ,
						stk_pkg::OP_NEQ, stk_pkg::OP_MUL: begin
							// both operands checked up front so a failure leaves the stack
							if (stk.depth < 2) begin
								fail(stk_pkg::ERR_DSEMPTY);
							end else begin
								opnd_b    <= stk.rdata;
								stk.pop   <= 1'b1;
								ret_state <= stk_pkg::S_SECOND;
							end
						end

						default: fail(stk_pkg::ERR_INVALID);
					endcase
				end

				stk_pkg::S_SECOND: begin
					opnd_a  <= stk.rdata;
					stk.pop <= 1'b1;
					state   <= stk_pkg::S_SETTLE;
					if (stk_pkg::opcode_e'(cur_op) == stk_pkg::OP_MUL) begin
						o_mul_start <= 1'b1;	// operands valid next cycle
						ret_state   <= stk_pkg::S_MUL_WAIT;
					end else begin
						ret_state <= stk_pkg::S_RESULT;
					end
				end

				stk_pkg::S_RESULT: begin
					stk.wdata <= i_alu_result;
					stk.push  <= 1'b1;
					ret_state <= stk_pkg::S_NEXT;
					state     <= stk_pkg::S_SETTLE;
				end

				stk_pkg::S_MUL_WAIT: begin
					if (i_mul_done) begin
						stk.wdata <= i_mul_product;
						stk.push  <= 1'b1;
						ret_state <= stk_pkg::S_NEXT;
						state     <= stk_pkg::S_SETTLE;
					end
				end

				stk_pkg::S_SETTLE: state <= ret_state;	// stack updates this cycle

				stk_pkg::S_NEXT: begin
					if (second) begin
						state <= stk_pkg::S_IDLE;
					end else begin
						cur_op <= instr_hi;
						second <= 1'b1;
						state  <= stk_pkg::S_EXEC;
					end
				end

				default: state <= stk_pkg::S_IDLE;
			endcase
		end
	end

	assign o_alu_op = stk_pkg::opcode_e'(cur_op);
	assign o_alu_a  = opnd_a;
	assign o_alu_b  = opnd_b;
	assign o_mul_a  = opnd_a;
	assign o_mul_b  = opnd_b;
	assign o_idle   = (state == stk_pkg::S_IDLE) && !i_push_en && !i_instr_en;

	a_push_pop_excl: assert property (
		@(posedge clk) disable iff (!rst_n) !(stk.push && stk.pop)
	) else $error("push and pop issued together");

	a_start_idle_mul: assert property (
		@(posedge clk) disable iff (!rst_n) o_mul_start |-> !i_mul_busy
	) else $error("multiplier started while busy");

endmodule

`default_nettype wire

// File: hw/stack_core.sv
// stack core top: controller with data stack, alu and serial multiplier
`default_nettype none

module stack_core (
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire logic [stk_pkg::DATA_W-1:0]   i_push_value,
	input  wire logic                         i_push_en,
	input  wire logic [stk_pkg::INSTR_W-1:0]  i_instr,
	input  wire logic                         i_instr_en,
	output logic                              o_idle,
	output stk_pkg::err_e                     o_errcode,
	output logic      [stk_pkg::DATA_W-1:0]   o_tos,
	output logic      [stk_pkg::DEPTH_W-1:0]  o_depth
);

	stack_if stk_bus ();

	stk_pkg::opcode_e           alu_op;
	logic [stk_pkg::DATA_W-1:0] alu_a;
	logic [stk_pkg::DATA_W-1:0] alu_b;
	logic [stk_pkg::DATA_W-1:0] alu_result;
	logic                       mul_start;
	logic                       mul_busy;
	logic                       mul_done;
	logic [stk_pkg::DATA_W-1:0] mul_a;
	logic [stk_pkg::DATA_W-1:0] mul_b;
	logic [stk_pkg::DATA_W-1:0] mul_product;

	core_ctrl core_ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_push_value (i_push_value),
		.i_push_en    (i_push_en),
		.i_instr      (i_instr),
		.i_instr_en   (i_instr_en),
		.i_alu_result (alu_result),
		.i_mul_busy   (mul_busy),
		.i_mul_done   (mul_done),
		.i_mul_product(mul_product),
		.stk          (stk_bus.ctrl),
		.o_alu_op     (alu_op),
		.o_alu_a      (alu_a),
		.o_alu_b      (alu_b),
		.o_mul_start  (mul_start),
		.o_mul_a      (mul_a),
		.o_mul_b      (mul_b),
		.o_idle       (o_idle),
		.o_errcode    (o_errcode)
	);

	data_stack data_stack_inst (
		.clk  (clk),
		.rst_n(rst_n),
		.stk  (stk_bus.mem)
	);

	stack_alu stack_alu_inst (
		.i_op    (alu_op),
		.i_a     (alu_a),
		.i_b     (alu_b),
		.o_result(alu_result)
	);

	serial_mul serial_mul_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_start  (mul_start),
		.i_a      (mul_a),
		.i_b      (mul_b),
		.o_busy   (mul_busy),
		.o_done   (mul_done),
		.o_product(mul_product)
	);

	// visible result is the stack itself
	assign o_tos   = stk_bus.rdata;
	assign o_depth = stk_bus.depth;

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
// testbench clock and reset: 20 ns clock, reset held low for the first 10 cycles
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 10;
	localparam int DRV_DELAY    = 2;	// same offset as the stimulus

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRV_DELAY;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/tb_stack_core.sv
// stack core testbench: reference stack model, stimulus and assertion checks
`default_nettype none

module tb_stack_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRV_DELAY    = 2;	// inputs change after the rising edge
	localparam int IDLE_TIMEOUT = 200;	// cycles, MUL needs about DATA_W
	localparam int RST_TIMEOUT  = 50;

	logic                        clk;
	logic                        rst_n;
	logic [stk_pkg::DATA_W-1:0]  push_value;
	logic                        push_en;
	logic [stk_pkg::INSTR_W-1:0] instr;
	logic                        instr_en;
	logic                        idle;
	stk_pkg::err_e               errcode;
	logic [stk_pkg::DATA_W-1:0]  tos;
	logic [stk_pkg::DEPTH_W-1:0] depth;

	logic [stk_pkg::DATA_W-1:0]  model [$];	// reference stack, top at the end
	logic [stk_pkg::DATA_W-1:0]  exp_tos;
	logic [stk_pkg::DEPTH_W-1:0] exp_depth;
	stk_pkg::err_e               exp_err;	// sticky, like the DUT
	logic                        chk_en;	// one cycle strobe for the concurrent checks
	string                       test_name;
	int                          test_errs;
	int                          tests_run;
	int                          tests_bad;
	int                          total_errs;
	integer                      seed;

	tb_clkgen clkgen_inst (
		.clk  (clk),
		.rst_n(rst_n)
	);

	stack_core stack_core_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_push_value(push_value),
		.i_push_en   (push_en),
		.i_instr     (instr),
		.i_instr_en  (instr_en),
		.o_idle      (idle),
		.o_errcode   (errcode),
		.o_tos       (tos),
		.o_depth     (depth)
	);

	a_depth_match: assert property (@(posedge clk) chk_en |-> depth == exp_depth)
		else begin
			$display("ERR %s depth expected %0d actual %0d", test_name, exp_depth, depth);
			test_errs++;
		end

	a_errcode_match: assert property (@(posedge clk) chk_en |-> errcode == exp_err)
		else begin
			$display("ERR %s errcode expected %0d actual %0d", test_name, exp_err, errcode);
			test_errs++;
		end

	function automatic logic [stk_pkg::DATA_W-1:0] rand_item();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[stk_pkg::DATA_W-1:0];
	endfunction

	function automatic logic [stk_pkg::DATA_W-1:0] unary_rule(
		input logic [stk_pkg::OPC_W-1:0]  op,
		input logic [stk_pkg::DATA_W-1:0] b
	);
		case (stk_pkg::opcode_e'(op))
			stk_pkg::OP_INC: return b + 1;
			stk_pkg::OP_DEC: return b - 1;
			stk_pkg::OP_NOT: return ~b;
			stk_pkg::OP_COM: return '0 - b;	// negate
			default:         return '0;
		endcase
	endfunction

	// a is the second item, b the top
	function automatic logic [stk_pkg::DATA_W-1:0] binary_rule(
		input logic [stk_pkg::OPC_W-1:0]  op,
		input logic [stk_pkg::DATA_W-1:0] a,
		input logic [stk_pkg::DATA_W-1:0] b
	);
		case (stk_pkg::opcode_e'(op))
			stk_pkg::OP_ADD:  return a + b;
			stk_pkg::OP_SUB:  return a - b;
			stk_pkg::OP_AND:  return a & b;
			stk_pkg::OP_OR:   return a | b;
			stk_pkg::OP_XOR:  return a ^ b;
			stk_pkg::OP_SHL:  return a << b;
			stk_pkg::OP_SHR:  return a >> b;
			stk_pkg::OP_GT:   return stk_pkg::DATA_W'(a > b);
			stk_pkg::OP_GTEQ: return stk_pkg::DATA_W'(a >= b);
			stk_pkg::OP_SM:   return stk_pkg::DATA_W'(a < b);
			stk_pkg::OP_SMEQ: return stk_pkg::DATA_W'(a <= b);
			stk_pkg::OP_EQ:   return stk_pkg::DATA_W'(a == b);
			stk_pkg::OP_NEQ:  return stk_pkg::DATA_W'(a != b);
			stk_pkg::OP_MUL:  return a * b;	// truncated to DATA_W
			default:          return '0;
		endcase
	endfunction

	// one opcode on the model, stack untouched on error
	function automatic stk_pkg::err_e model_op(input logic [stk_pkg::OPC_W-1:0] op);
		logic [stk_pkg::DATA_W-1:0] a;
		logic [stk_pkg::DATA_W-1:0] b;
		int                         n;
		n = model.size();
		if (op > stk_pkg::OP_MUL) return stk_pkg::ERR_INVALID;
		case (stk_pkg::opcode_e'(op))
			stk_pkg::OP_NOP: return stk_pkg::ERR_NONE;
			stk_pkg::OP_DEPTH: begin
				if (n == stk_pkg::STACK_DEPTH) return stk_pkg::ERR_DSFULL;
				model.push_back(stk_pkg::DATA_W'(n));
			end
			stk_pkg::OP_DUP: begin
				if (n == 0) return stk_pkg::ERR_DSEMPTY;
				if (n == stk_pkg::STACK_DEPTH) return stk_pkg::ERR_DSFULL;
				model.push_back(model[n-1]);
			end
			stk_pkg::OP_DROP: begin
				if (n == 0) return stk_pkg::ERR_DSEMPTY;
				model.delete(n - 1);
			end
			stk_pkg::OP_INC, stk_pkg::OP_DEC, stk_pkg::OP_NOT, stk_pkg::OP_COM: begin
				if (n == 0) return stk_pkg::ERR_DSEMPTY;
				b = model.pop_back();
				model.push_back(unary_rule(op, b));
			end
			default: begin	// two-operand words
				if (n < 2) return stk_pkg::ERR_DSEMPTY;
				b = model.pop_back();
				a = model.pop_back();
				model.push_back(binary_rule(op, a, b));
			end
		endcase
		return stk_pkg::ERR_NONE;
	endfunction

	task automatic wait_idle();
		int n;
		n = 0;
		while (!idle && n < IDLE_TIMEOUT) begin
			@(posedge clk);
			#DRV_DELAY;
			n++;
		end
		if (!idle) begin
			$display("timeout: core never returned to idle in test %s", test_name);
			$display("sim failed");
			$finish;
		end
	endtask

	task automatic check_state();
		exp_depth = stk_pkg::DEPTH_W'(model.size());
		if (model.size() > 0) begin
			exp_tos = model[$];
		end else begin
			exp_tos = '0;	// empty stack reads zero
		end
		assert (tos == exp_tos) else begin
			$display("ERR %s tos expected %h actual %h", test_name, exp_tos, tos);
			test_errs++;
		end
		chk_en = 1'b1;
		@(posedge clk);
		#DRV_DELAY;
		chk_en = 1'b0;
	endtask

	task automatic push_item(input logic [stk_pkg::DATA_W-1:0] v);
		push_value = v;
		push_en    = 1'b1;
		@(posedge clk);
		#DRV_DELAY;
		push_en = 1'b0;
		wait_idle();
		if (model.size() == stk_pkg::STACK_DEPTH) begin
			exp_err = stk_pkg::ERR_DSFULL;
		end else begin
			model.push_back(v);
		end
		check_state();
	endtask

	task automatic run_word(
		input logic [stk_pkg::OPC_W-1:0] lo,
		input logic [stk_pkg::OPC_W-1:0] hi
	);
		stk_pkg::err_e e;
		instr    = {hi, lo};
		instr_en = 1'b1;
		@(posedge clk);
		#DRV_DELAY;
		instr_en = 1'b0;
		wait_idle();
		e = model_op(lo);
		if (e == stk_pkg::ERR_NONE) e = model_op(hi);	// error skips the high opcode
		if (e != stk_pkg::ERR_NONE) exp_err = e;
		check_state();
	endtask

	task automatic clear_stack();
		while (model.size() > 0) run_word(stk_pkg::OP_DROP, stk_pkg::OP_NOP);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_bad++;
			$display("test %s: %0d mismatches", test_name, test_errs);
		end
	endtask

	task automatic run_tests();
		logic [stk_pkg::DATA_W-1:0] a;
		logic [stk_pkg::DATA_W-1:0] b;
		begin_test("reset");
		wait_idle();	// idle, empty and no error out of reset
		check_state();
		end_test();

		begin_test("push");
		for (int i = 0; i < 5; i++) push_item(rand_item());
		end_test();

		begin_test("stack_words");
		run_word(stk_pkg::OP_DEPTH, stk_pkg::OP_NOP);	// pushes 5
		run_word(stk_pkg::OP_DUP, stk_pkg::OP_NOP);
		run_word(stk_pkg::OP_DROP, stk_pkg::OP_NOP);
		run_word(stk_pkg::OP_DROP, stk_pkg::OP_NOP);	// back to the last push
		clear_stack();
		end_test();

		begin_test("binary");
		for (int op = int'(stk_pkg::OP_ADD); op <= int'(stk_pkg::OP_NEQ); op++) begin
			for (int rep = 0; rep < 2; rep++) begin
				a = rand_item();
				b = rand_item();
				if (op == int'(stk_pkg::OP_SHL) || op == int'(stk_pkg::OP_SHR)) b = b & 'h3f;
				if (rep == 1) a = b;	// equal operands for the compares
				push_item(a);
				push_item(b);
				run_word(stk_pkg::OPC_W'(op), stk_pkg::OP_NOP);
				clear_stack();
			end
		end
		end_test();

		begin_test("unary");
		for (int op = int'(stk_pkg::OP_INC); op <= int'(stk_pkg::OP_COM); op++) begin
			for (int rep = 0; rep < 2; rep++) begin
				push_item((rep == 0) ? rand_item() : '0);	// zero hits the wrap cases
				run_word(stk_pkg::OPC_W'(op), stk_pkg::OP_NOP);
				clear_stack();
			end
		end
		end_test();

		begin_test("mul");
		for (int i = 0; i < 4; i++) begin
			push_item(rand_item());
			push_item(rand_item());
			run_word(stk_pkg::OP_MUL, stk_pkg::OP_NOP);
			clear_stack();
		end
		end_test();

		begin_test("two_opcodes");
		push_item(3);
		push_item(4);
		run_word(stk_pkg::OP_ADD, stk_pkg::OP_INC);	// add first, then inc
		assert (tos == 8) else begin
			$display("ERR %s tos expected %h actual %h", test_name, 8, tos);
			test_errs++;
		end
		clear_stack();
		push_item(rand_item());
		run_word(stk_pkg::OP_DUP, stk_pkg::OP_MUL);	// square
		clear_stack();
		end_test();

		begin_test("err_empty");
		run_word(stk_pkg::OP_DROP, stk_pkg::OP_DEPTH);	// depth must stay 0
		end_test();

		begin_test("err_full");
		for (int i = 0; i < stk_pkg::STACK_DEPTH; i++) push_item(rand_item());
		push_item(rand_item());	// ninth
		run_word(stk_pkg::OP_DUP, stk_pkg::OP_DROP);
		end_test();

		begin_test("err_invalid");
		run_word(7'd22, stk_pkg::OP_DROP);
		run_word(7'd127, stk_pkg::OP_DROP);
		end_test();
	endtask

	initial begin
		int n;
		push_value = '0;
		push_en    = 1'b0;
		instr      = '0;
		instr_en   = 1'b0;
		chk_en     = 1'b0;
		exp_tos    = '0;
		exp_depth  = '0;
		exp_err    = stk_pkg::ERR_NONE;
		seed       = 32'hb691_719b;
		tests_run  = 0;
		tests_bad  = 0;
		total_errs = 0;
		test_name  = "reset";
		test_errs  = 0;
		n = 0;
		while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			$display("sim failed");
			$finish;
		end else begin
			@(posedge clk);
			#DRV_DELAY;
			run_tests();
			$display("tests %0d, failing tests %0d, mismatches %0d",
			         tests_run, tests_bad, total_errs);
			if (total_errs == 0 && tests_bad == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/stk_pkg.sv
hw/stack_if.sv
hw/data_stack.sv
hw/stack_alu.sv
hw/serial_mul.sv
hw/core_ctrl.sv
hw/stack_core.sv
sim/tb_clkgen.sv
sim/tb_stack_core.sv

// File: Makefile
# Verilator build and run of the stack core testbench

VERILATOR ?= verilator
TOP       ?= tb_stack_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
